//--- all.f
+incdir+src
src/isa_pkg.sv
src/board_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/cpu.sv
src/board_top.sv
tests/board_top_sva.sv
tests/board_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the fail verdict in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f all.f --top-module board_top_tb \
    -o board_top_tb_sim > build.log 2>&1 \
    && ./obj_dir/board_top_tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
echo "simulation finished without failure"

//--- src/board_pkg.sv
/*
 * board level types: LED drive, run control states, status word
 */
package board_pkg;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_t;

    typedef enum logic [1:0] {
        WAIT_START,                     // start-up delay after reset
        IDLE,                           // ready for go
        RUN,                            // cpu executing
        DONE                            // halted, verdict latched
    } run_state_t;

    // read back through REG_STATUS, startup_done in bit 3
    typedef struct packed {
        logic startup_done;
        logic running;
        logic halted;
        logic passed;                   // bit 0
    } status_t;

endpackage

//--- src/board_top.sv
/*
 * board wrapper: APB registers, start-up delay and run control around the cpu
 * LED shows blue while running, then green for pass or red for fail
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module board_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [`APB_AW-1:0]  paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output board_pkg::led_t     leds
);
    import isa_pkg::*;
    import board_pkg::*;

    localparam int CNT_W = $clog2(`STARTUP_CYCLES);

    run_state_t       state;
    logic [CNT_W-1:0] cnt;                   // start-up delay
    logic             start_q;
    logic             passed_q;
    logic             running;
    status_t          status;
    logic             access, wr;
    logic             prog_sel, ctrl_sel, stat_sel;
    logic             go_req, go_bad, go, prog_bad, unmapped;
    logic             prog_we;
    word_t            prog_rdata;
    logic             cpu_halt, cpu_pass;

    assign running = (state == RUN);
    assign status  = '{
        startup_done: (state != WAIT_START),
        running:      running,
        halted:       (state == DONE),
        passed:       passed_q
    };

    // APB decode, zero wait states
    assign access   = psel & penable;
    assign wr       = access & pwrite;
    assign prog_sel = (paddr[`APB_AW-1:`PROG_AW+2] == '0);  // below PROG_DEPTH*4
    assign ctrl_sel = (paddr == `REG_CTRL);
    assign stat_sel = (paddr == `REG_STATUS);

    assign go_req   = wr & ctrl_sel & pwdata[0];
    assign go_bad   = go_req & (state == WAIT_START || state == RUN);
    assign go       = go_req & ~go_bad;
    assign prog_bad = wr & prog_sel & running;   // memory locked during a run
    assign unmapped = access & ~(prog_sel | ctrl_sel | stat_sel);
    assign prog_we  = wr & prog_sel & ~running;

    assign pready  = 1'b1;
    assign pslverr = go_bad | prog_bad | unmapped;
    assign prdata  = prog_sel ? {16'b0, prog_rdata} :
                     stat_sel ? {28'b0, status} : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WAIT_START;
            cnt      <= '0;
            start_q  <= 1'b0;
            passed_q <= 1'b0;
        end else begin
            start_q <= go;                   // pulse one cycle after go
            case (state)
                WAIT_START: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`STARTUP_CYCLES - 1)) state <= IDLE;
                end
                IDLE, DONE: if (go) begin
                    state    <= RUN;
                    passed_q <= 1'b0;        // old verdict gone
                end
                RUN: if (cpu_halt) begin
                    state    <= DONE;
                    passed_q <= cpu_pass;
                end
                default: state <= WAIT_START;
            endcase
        end
    end

    cpu u_cpu (
        .clk        (clk),
        .rst        (rst),
        .start      (start_q),
        .prog_we    (prog_we),
        .prog_addr  (paddr[`PROG_AW+1:2]),   // word index
        .prog_wdata (pwdata[15:0]),
        .prog_rdata (prog_rdata),
        .halt       (cpu_halt),
        .pass       (cpu_pass)
    );

    // one LED lit at a time
    assign leds = '{
        red:   ~running & ~passed_q,
        green: ~running & passed_q,
        blue:  running
    };

endmodule

//--- src/cpu.sv
/*
 * three stage accumulator cpu, fetch -> decode -> execute
 * taken branches and halts flush the younger stages
 */
`timescale 1ns/1ns

module cpu (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,           // one cycle pulse from run control
    input  logic            prog_we,
    input  isa_pkg::pc_t    prog_addr,
    input  isa_pkg::word_t  prog_wdata,
    output isa_pkg::word_t  prog_rdata,
    output logic            halt,            // one cycle pulse at end of run
    output logic            pass
);
    import isa_pkg::*;

    fetched_t fetched;
    decoded_t decoded;
    logic     flush;
    pc_t      redirect;
    logic     dec_flush;

    // halt also empties decode so the next run starts clean
    assign dec_flush = flush | halt;

    fetch_stage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .flush      (flush),
        .redirect   (redirect),
        .halt       (halt),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .prog_rdata (prog_rdata),
        .fetched    (fetched)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .flush   (dec_flush),
        .fetched (fetched),
        .decoded (decoded)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .decoded  (decoded),
        .flush    (flush),
        .redirect (redirect),
        .halt     (halt),
        .pass     (pass)
    );

endmodule

//--- src/cpu_cfg.svh
/*
 * self-test subsystem configuration
 * program size, start-up delay and APB register map
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// program memory
`define PROG_DEPTH 256                  // words
`define PROG_AW 8                       // word index width

// cycles held off after reset
`define STARTUP_CYCLES 64

// APB register map, byte addresses
`define APB_AW 12
`define REG_CTRL 12'h400                // bit 0 = go
`define REG_STATUS 12'h404              // status_t in bits 3:0

`endif

//--- src/decode_stage.sv
/*
 * decode stage splitting the fetched word into opcode, imm and target
 * undefined opcodes become HALT_FAIL
 */
`timescale 1ns/1ns

module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,          // drop the instruction held here
    input  isa_pkg::fetched_t fetched,
    output isa_pkg::decoded_t decoded
);
    import isa_pkg::*;

    logic [OP_W-1:0] op_raw;
    opcode_t         op_map;
    logic            valid_q;
    opcode_t         op_q;
    data_t           imm_q;
    pc_t             target_q;

    assign op_raw = fetched.word[OP_LSB +: OP_W];

    // anything past the last defined code fails the run
    always_comb begin
        if (op_raw > OP_W'(HALT_FAIL)) begin
            op_map = HALT_FAIL;
        end else begin
            op_map = opcode_t'(op_raw);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;                 // younger than the branch
        end else begin
            valid_q <= fetched.valid;
        end
    end

    // opcode, immediate and target fields
    always_ff @(posedge clk) begin
        op_q     <= op_map;
        imm_q    <= data_t'(fetched.word);   // low byte
        target_q <= pc_t'(fetched.word);     // same bits read as an address
    end

    assign decoded = '{
        valid:  valid_q,
        opcode: op_q,
        imm:    imm_q,
        target: target_q
    };

endmodule

//--- src/execute_stage.sv
/*
 * execute stage: accumulator and zero flag, branch resolution, halt verdict
 * flush, redirect and halt are combinational from the decoded instruction
 */
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  isa_pkg::decoded_t decoded,
    output logic              flush,
    output isa_pkg::pc_t      redirect,
    output logic              halt,
    output logic              pass           // valid with halt
);
    import isa_pkg::*;

    data_t acc;
    logic  zero;
    logic  armed;                            // cleared by halt until next start
    logic  exec;
    data_t result;
    logic  zero_next;
    logic  writes_acc;
    logic  sets_zero;
    logic  taken;
    logic  is_halt;

    assign exec = armed & decoded.valid;

    always_comb begin
        result     = acc;
        writes_acc = 1'b0;
        sets_zero  = 1'b0;
        taken      = 1'b0;
        is_halt    = 1'b0;
        case (decoded.opcode)
            LDI:  begin result = decoded.imm;       writes_acc = 1'b1; end
            ADDI: begin result = acc + decoded.imm; writes_acc = 1'b1; end
            SUBI: begin result = acc - decoded.imm; writes_acc = 1'b1; end
            XORI: begin result = acc ^ decoded.imm; writes_acc = 1'b1; end
            CMPI: sets_zero = 1'b1;          // acc untouched
            JMP:  taken = 1'b1;
            JZ:   taken = zero;
            JNZ:  taken = ~zero;
            HALT_PASS, HALT_FAIL: is_halt = 1'b1;
            default: ;                       // NOP
        endcase
        // CMPI compares, the rest test their result
        zero_next = (decoded.opcode == CMPI) ? (acc == decoded.imm) : (result == '0);
    end

    assign flush    = exec & taken;
    assign redirect = decoded.target;
    assign halt     = exec & is_halt;
    assign pass     = (decoded.opcode == HALT_PASS);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc   <= '0;
            zero  <= 1'b0;
            armed <= 1'b0;
        end else if (start) begin
            acc   <= '0;                     // fresh run
            zero  <= 1'b0;
            armed <= 1'b1;
        end else if (exec) begin
            if (writes_acc) acc <= result;
            if (writes_acc || sets_zero) zero <= zero_next;
            if (is_halt) armed <= 1'b0;      // ignore stragglers
        end
    end

endmodule

//--- src/fetch_stage.sv
/*
 * fetch stage: program memory with host port, PC and registered fetch
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,          // run begins, pc back to 0
    input  logic             flush,          // taken branch in execute
    input  isa_pkg::pc_t     redirect,
    input  logic             halt,
    input  logic             prog_we,        // host write
    input  isa_pkg::pc_t     prog_addr,
    input  isa_pkg::word_t   prog_wdata,
    output isa_pkg::word_t   prog_rdata,
    output isa_pkg::fetched_t fetched
);
    import isa_pkg::*;

    word_t mem [`PROG_DEPTH];                // program store
    pc_t   pc;
    logic  active;                           // between start and halt
    logic  valid_q;
    pc_t   pc_q;
    word_t word_q;

    // host side, write by word index, async read back
    always_ff @(posedge clk) begin
        if (prog_we) mem[prog_addr] <= prog_wdata;
    end
    assign prog_rdata = mem[prog_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            active  <= 1'b0;
            valid_q <= 1'b0;
        end else if (start) begin
            pc      <= '0;
            active  <= 1'b1;
            valid_q <= 1'b0;
        end else if (halt) begin
            active  <= 1'b0;                 // stop fetching
            valid_q <= 1'b0;
        end else if (flush) begin
            pc      <= redirect;
            valid_q <= 1'b0;                 // word in flight is wrong path
        end else begin
            valid_q <= active;
            if (active) pc <= pc + 1'b1;     // wraps at end of memory
        end
    end

    // payload, qualified by valid_q
    always_ff @(posedge clk) begin
        pc_q   <= pc;
        word_q <= mem[pc];
    end

    assign fetched = '{valid: valid_q, pc: pc_q, word: word_q};

endmodule

//--- src/isa_pkg.sv
/*
 * accumulator ISA types
 * word layout [15:12] opcode, [11:8] reserved, [7:0] imm or target
 */
`include "cpu_cfg.svh"

package isa_pkg;

    localparam int OP_LSB = 12;         // opcode field position
    localparam int OP_W = 4;

    typedef logic [15:0] word_t;        // one instruction word
    typedef logic [7:0] data_t;         // accumulator width
    typedef logic [`PROG_AW-1:0] pc_t;  // program address

    // encodings above HALT_FAIL are undefined, decoded as HALT_FAIL
    typedef enum logic [OP_W-1:0] {
        NOP       = 4'h0,
        LDI       = 4'h1,               // acc = imm
        ADDI      = 4'h2,
        SUBI      = 4'h3,
        XORI      = 4'h4,
        CMPI      = 4'h5,               // zero = (acc == imm), acc kept
        JMP       = 4'h6,
        JZ        = 4'h7,
        JNZ       = 4'h8,
        HALT_PASS = 4'h9,
        HALT_FAIL = 4'hA
    } opcode_t;

    // fetch -> decode
    typedef struct packed {
        logic  valid;
        pc_t   pc;                      // address the word came from
        word_t word;
    } fetched_t;

    // decode -> execute
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        data_t   imm;
        pc_t     target;                // branch target, low bits of word
    } decoded_t;

endpackage

//--- tests/board_top_sva.sv
/*
 * bound checks on board_top: APB ready, LED drive and run control
 */
`timescale 1ns/1ns

module board_top_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  pready,
    input logic                  cpu_halt,         // halt pulse from the cpu
    input board_pkg::led_t       leds,
    input board_pkg::run_state_t state,
    input board_pkg::status_t    status
);
    import board_pkg::*;

    // zero wait state slave
    a_pready: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped low");

    // red, green or blue, never two
    a_one_led: assert property (@(posedge clk) disable iff (rst) $onehot(leds))
        else $error("LED drive not one-hot: %b", leds);

    a_run_halt: assert property (@(posedge clk) disable iff (rst)
        !(status.running && status.halted))
        else $error("running and halted both set");

    // only a halt pulse ends a run
    a_leave_run: assert property (@(posedge clk) disable iff (rst)
        (state == RUN && !cpu_halt) |=> state == RUN)
        else $error("left RUN without a halt pulse");

endmodule

bind board_top board_top_sva u_board_top_sva (
    .clk      (clk),
    .rst      (rst),
    .pready   (pready),
    .cpu_halt (cpu_halt),
    .leds     (leds),
    .state    (state),
    .status   (status)
);

//--- tests/board_top_tb.sv
/*
 * board_top testbench loading programs over APB, running them
 * and checking LED colour and status against the ISA rules
 */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module board_top_tb;
    import isa_pkg::*;
    import board_pkg::*;

    typedef logic [`APB_AW-1:0] apb_addr_t;

    localparam logic [2:0] LED_RED   = 3'b100;     // {red, green, blue}
    localparam logic [2:0] LED_GREEN = 3'b010;
    localparam logic [2:0] LED_BLUE  = 3'b001;

    logic        clk, rst;
    logic        psel, penable, pwrite, pready, pslverr;
    apb_addr_t   paddr;
    logic [31:0] pwdata, prdata;
    led_t        leds;
    int          errors, timeouts;
    word_t       prog_q[$];                        // program being built

    board_top u_board_top (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .leds(leds)
    );

    always #5 clk = ~clk;                          // 10 ns period

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    endtask

    // setup then access phase with results sampled mid access cycle
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err = pslverr;
        if (pready !== 1'b1) report_mismatch("pready in access phase", {31'b0, pready}, 32'h1);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        apb_xfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
        apb_xfer(1'b0, addr, 32'h0, data, err);
    endtask

    // bounded poll of REG_STATUS until one bit sets
    task automatic wait_status_bit(input int idx, input int max_polls);
        logic [31:0] rd;
        logic        err;
        int          n;
        rd = '0;
        n = 0;
        while (rd[idx] !== 1'b1 && n < max_polls) begin
            apb_read(`REG_STATUS, rd, err);
            n++;
        end
        if (rd[idx] !== 1'b1) begin
            timeouts++;
            $display("timeout: status bit %0d still clear after %0d polls", idx, max_polls);
        end
    endtask

    // {opcode, reserved zero, imm or target}
    function automatic word_t enc(input opcode_t op, input data_t imm);
        return {op, 4'h0, imm};
    endfunction

    // accumulator reference with 8 bit wrap
    function automatic data_t model_op(input data_t acc, input opcode_t op, input data_t imm);
        case (op)
            ADDI:    return acc + imm;
            SUBI:    return acc - imm;
            XORI:    return acc ^ imm;
            default: return acc;
        endcase
    endfunction

    task automatic load_prog();
        logic err;
        for (int i = 0; i < prog_q.size(); i++) begin
            apb_write(apb_addr_t'(i * 4), {16'h0, prog_q[i]}, err);
            if (err !== 1'b0) report_mismatch("program load pslverr", {31'b0, err}, 32'h0);
        end
    endtask

    task automatic start_run(input string what);
        logic err;
        apb_write(`REG_CTRL, 32'h1, err);
        if (err !== 1'b0) report_mismatch({what, " go pslverr"}, {31'b0, err}, 32'h0);
        if (leds !== LED_BLUE) report_mismatch({what, " leds running"}, {29'b0, leds}, 32'h1);
    endtask

    task automatic finish_run(input logic exp_pass, input string what);
        logic [31:0] rd;
        logic        err;
        logic [31:0] exp_st;
        logic [2:0]  exp_led;
        wait_status_bit(1, 1000);
        exp_st = {28'b0, 3'b101, exp_pass};         // startup_done, halted, passed
        exp_led = exp_pass ? LED_GREEN : LED_RED;
        apb_read(`REG_STATUS, rd, err);
        if (rd !== exp_st) report_mismatch({what, " status"}, rd, exp_st);
        if (leds !== exp_led) report_mismatch({what, " leds"}, {29'b0, leds}, {29'b0, exp_led});
    endtask

    task automatic run_program(input logic exp_pass, input string what);
        load_prog();
        start_run(what);
        finish_run(exp_pass, what);
    endtask

    task automatic startup_reset();
        logic [31:0] rd;
        logic        err;
        apb_read(`REG_STATUS, rd, err);
        if (rd !== 32'h0) report_mismatch("status after reset", rd, 32'h0);
        if (leds !== LED_RED) report_mismatch("leds after reset", {29'b0, leds}, 32'h4);
        apb_write(`REG_CTRL, 32'h1, err);            // still in start-up delay
        if (err !== 1'b1) report_mismatch("early go pslverr", {31'b0, err}, 32'h1);
        apb_read(`REG_STATUS, rd, err);
        if (rd !== 32'h0) report_mismatch("status after early go", rd, 32'h0);
        wait_status_bit(3, 100);
        apb_read(`REG_STATUS, rd, err);
        if (rd !== 32'h8) report_mismatch("status after start-up", rd, 32'h8);
    endtask

    task automatic prog_mem_access();
        int          idx [8];
        word_t       dat [8];
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            idx[i] = i * 32 + int'($urandom % 32);  // distinct slots
            dat[i] = 16'($urandom);
            apb_write(apb_addr_t'(idx[i] * 4), {16'h0, dat[i]}, err);
            if (err !== 1'b0) report_mismatch("program write pslverr", {31'b0, err}, 32'h0);
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(apb_addr_t'(idx[i] * 4), rd, err);
            if (rd !== {16'h0, dat[i]}) report_mismatch("program read back", rd, {16'h0, dat[i]});
        end
        apb_read(12'h800, rd, err);
        if (err !== 1'b1) report_mismatch("unmapped read pslverr", {31'b0, err}, 32'h1);
        apb_write(12'h408, 32'h1, err);
        if (err !== 1'b1) report_mismatch("unmapped write pslverr", {31'b0, err}, 32'h1);
    endtask

    task automatic pass_program();
        data_t a, b;
        a = 8'($urandom);
        b = 8'($urandom);
        prog_q.delete();
        prog_q.push_back(enc(LDI, a));
        prog_q.push_back(enc(ADDI, b));
        prog_q.push_back(enc(CMPI, a + b));          // expected sum with wrap
        prog_q.push_back(enc(JZ, 8'd5));
        prog_q.push_back(enc(HALT_FAIL, 8'd0));      // fall through
        prog_q.push_back(enc(HALT_PASS, 8'd0));
        run_program(1'b1, "pass program");
    endtask

    task automatic fail_programs();
        prog_q.delete();
        prog_q.push_back(enc(HALT_FAIL, 8'd0));
        run_program(1'b0, "fail program");
        prog_q.delete();
        prog_q.push_back(enc(NOP, 8'd0));
        prog_q.push_back(16'hF000);                  // undefined opcode
        prog_q.push_back(enc(HALT_PASS, 8'd0));
        run_program(1'b0, "undefined opcode");
    endtask

    task automatic random_arith(input logic off_by_one);
        data_t   acc, imm, cmp;
        opcode_t op;
        int      n, p;
        logic    exp_zero;
        prog_q.delete();
        acc = 8'($urandom);
        prog_q.push_back(enc(LDI, acc));
        n = 3 + int'($urandom % 8);
        for (int k = 0; k < n; k++) begin
            case ($urandom % 3)
                0:       op = ADDI;
                1:       op = SUBI;
                default: op = XORI;
            endcase
            imm = 8'($urandom);
            acc = model_op(acc, op, imm);
            prog_q.push_back(enc(op, imm));
        end
        cmp = off_by_one ? acc + 8'd1 : acc;
        exp_zero = (acc == cmp);                     // model zero flag after CMPI
        p = prog_q.size();
        prog_q.push_back(enc(CMPI, cmp));
        prog_q.push_back(enc(JZ, 8'(p + 3)));        // to HALT_PASS
        prog_q.push_back(enc(HALT_FAIL, 8'd0));
        prog_q.push_back(enc(HALT_PASS, 8'd0));
        run_program(exp_zero, off_by_one ? "random off by one" : "random arith");
    endtask

    task automatic branch_and_protect();
        logic [31:0] rd;
        logic        err;
        prog_q.delete();
        prog_q.push_back(enc(JMP, 8'd3));
        prog_q.push_back(enc(HALT_FAIL, 8'd0));      // flushed
        prog_q.push_back(enc(HALT_FAIL, 8'd0));      // flushed
        prog_q.push_back(enc(HALT_PASS, 8'd0));
        run_program(1'b1, "jmp over fail");
        apb_write(apb_addr_t'(40), 32'h1234, err);
        if (err !== 1'b0) report_mismatch("write before run pslverr", {31'b0, err}, 32'h0);
        prog_q.delete();
        prog_q.push_back(enc(LDI, 8'd200));          // count down loop
        prog_q.push_back(enc(SUBI, 8'd1));
        prog_q.push_back(enc(JNZ, 8'd1));
        prog_q.push_back(enc(HALT_PASS, 8'd0));
        load_prog();
        start_run("long loop");
        apb_write(apb_addr_t'(40), 32'hBEEF, err);   // locked while running
        if (err !== 1'b1) report_mismatch("write during run pslverr", {31'b0, err}, 32'h1);
        finish_run(1'b1, "long loop");
        apb_read(apb_addr_t'(40), rd, err);
        if (rd !== 32'h1234) report_mismatch("word after rejected write", rd, 32'h1234);
    endtask

    initial begin
        void'($urandom(12624));                    // fixed seed
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        errors = 0;
        timeouts = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        startup_reset();
        prog_mem_access();
        pass_program();
        fail_programs();
        for (int r = 0; r < 4; r++) random_arith(1'b0);
        random_arith(1'b1);
        branch_and_protect();
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
